// File: flist.f
board_pkg.sv
video_pkg.sv
slow_clk_gen.sv
vga_timing.sv
seven_seg_scan.sv
lab_top.sv
board_specific_top.sv
board_properties.sv
tb_checker.sv
tb_board.sv

// File: tb_board.sv
`timescale 1ns/10ps

module tb_board;

    import board_pkg::*;
    import video_pkg::*;

    localparam int sim_slow_div   = 50;
    localparam int key_cycles     = 2000;
    localparam int scan_cycles    = 2 * w_digit * scan_div;
    localparam int timeout_cycles = 2 * h_total * v_total + key_cycles + scan_cycles;

    logic   clk;
    logic   arst_n;
    key_t   KEY;
    led_t   LED;
    segs_t  abcdefgh;
    digit_t digit;
    logic   hsync;
    logic   vsync;
    logic   display_on;
    color_t red;
    color_t green;
    color_t blue;
    int     cycles;
    int     total;

    // ------------------------------
    // reference model
    // ------------------------------

    // {red, green, blue}, black outside the active area
    function automatic logic [23:0] exp_color(input int x, input int y, input mode_t mode);
        logic [23:0] rgb;
        x_t          xv;
        y_t          yv;
        xv  = x_t'(x);
        yv  = y_t'(y);
        rgb = '0;
        if (x < h_active && y < v_active)
        begin
            case (mode)
                mode_bars:
                begin
                    if (xv[6])
                        rgb[23:16] = 8'hff;
                    if (xv[7])
                        rgb[15:8] = 8'hff;
                    if (xv[8])
                        rgb[7:0] = 8'hff;
                end
                mode_checker:
                begin
                    if (xv[5] != yv[5])
                        rgb = '1;
                end
                default:
                    rgb = '1;
            endcase
        end
        return rgb;
    endfunction

    function automatic segs_t exp_segs(input logic [3:0] nibble);
        logic [6:0] abcdefg;
        case (nibble)
            4'h0:    abcdefg = 7'b1111110;
            4'h1:    abcdefg = 7'b0110000;
            4'h2:    abcdefg = 7'b1101101;
            4'h3:    abcdefg = 7'b1111001;
            4'h4:    abcdefg = 7'b0110011;
            4'h5:    abcdefg = 7'b1011011;
            4'h6:    abcdefg = 7'b1011111;
            4'h7:    abcdefg = 7'b1110000;
            4'h8:    abcdefg = 7'b1111111;
            4'h9:    abcdefg = 7'b1111011;
            4'ha:    abcdefg = 7'b1110111;
            4'hb:    abcdefg = 7'b0011111;
            4'hc:    abcdefg = 7'b1001110;
            4'hd:    abcdefg = 7'b0111101;
            4'he:    abcdefg = 7'b1001111;
            default: abcdefg = 7'b1000111;
        endcase
        return {abcdefg, 1'b0};
    endfunction

    function automatic mode_t next_mode(input mode_t mode);
        case (mode)
            mode_bars:    return mode_checker;
            mode_checker: return mode_solid;
            default:      return mode_bars;
        endcase
    endfunction

    // random gap, then a press of at least 4 cycles
    task automatic press_key(input int idx);
        int gap;
        int len;
        gap = 20 + ($urandom % 181);
        len = 4 + ($urandom % 8);
        repeat (gap) @(posedge clk);
        #2;
        KEY[idx] = 1'b0;
        repeat (len) @(posedge clk);
        #2;
        KEY[idx] = 1'b1;
    endtask

    board_specific_top #(.slow_div (sim_slow_div)) dut
    (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .KEY        ( KEY        ),
        .LED        ( LED        ),
        .abcdefgh   ( abcdefgh   ),
        .digit      ( digit      ),
        .hsync      ( hsync      ),
        .vsync      ( vsync      ),
        .display_on ( display_on ),
        .red        ( red        ),
        .green      ( green      ),
        .blue       ( blue       )
    );

    tb_checker #(.slow_div (sim_slow_div)) chk
    (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .KEY        ( KEY        ),
        .LED        ( LED        ),
        .abcdefgh   ( abcdefgh   ),
        .digit      ( digit      ),
        .hsync      ( hsync      ),
        .vsync      ( vsync      ),
        .display_on ( display_on ),
        .red        ( red        ),
        .green      ( green      ),
        .blue       ( blue       )
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial
    begin
        cycles = 0;
        while (cycles < timeout_cycles)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
        $display("Errors found");
        $finish;
    end

    // ------------------------------
    // test sequence
    // ------------------------------

    initial
    begin
        void'($urandom(32'haa47c691));
        KEY    = '1;
        arst_n = 1'b0;
        repeat (10) @(posedge clk);
        #2;
        arst_n = 1'b1;

        repeat (4 * sim_slow_div + 10) @(posedge clk);
        chk.end_test("reset and LED stepping");

        @(posedge display_on);
        repeat (h_total * v_total) @(posedge clk);
        chk.end_test("raster timing over one frame");

        // bars, checker, solid and back to bars
        repeat (3) press_key(0);
        repeat (200) @(posedge clk);
        chk.end_test("colour patterns in every mode");

        repeat (2)
        begin
            press_key(1);
            repeat (2 * sim_slow_div + 5) @(posedge clk);
        end
        chk.end_test("counter clear");

        repeat (scan_cycles) @(posedge clk);
        chk.end_test("seven-segment scan");

        total = chk.errors + dut.i_vga_timing.props.failures;
        $display("%0d tests, %0d failed, %0d mismatches, %0d assertion failures",
                 chk.test_num, chk.tests_failed, chk.errors, dut.i_vga_timing.props.failures);
        if (total == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// File: tb_checker.sv
`timescale 1ns/10ps

module tb_checker
#(
    parameter int slow_div = board_pkg::slow_div
)
(
    input logic              clk,
    input logic              arst_n,
    input board_pkg::key_t   KEY,
    input board_pkg::led_t   LED,
    input board_pkg::segs_t  abcdefgh,
    input board_pkg::digit_t digit,
    input logic              hsync,
    input logic              vsync,
    input logic              display_on,
    input video_pkg::color_t red,
    input video_pkg::color_t green,
    input video_pkg::color_t blue
);

    import board_pkg::*;
    import video_pkg::*;

    localparam int max_lines = 20;

    int     errors        = 0;
    int     errors_before = 0;
    int     test_num      = 0;
    int     tests_failed  = 0;
    int     cyc;
    int     tx;
    int     ty;
    count_t count;
    mode_t  mode;
    key_t   pressed [0:4];
    int     color_hold;
    int     segs_hold;
    logic   rise_seen;
    logic   display_prev;

    task automatic flag_mismatch(input string name, input logic [23:0] exp_val,
                                 input logic [23:0] act_val);
        errors++;
        if (errors <= max_lines)
            $display("Error: %s expected %h got %h at cycle %0d", name, exp_val, act_val, cyc);
    endtask

    task automatic flag_event(input string what);
        errors++;
        if (errors <= max_lines)
            $display("%s, cycle %0d", what, cyc);
    endtask

    // called by the testbench top when a test phase ends
    task automatic end_test(input string name);
        int n;
        n = errors - errors_before;
        test_num++;
        if (n == 0)
            $display("test %0d %s: passed", test_num, name);
        else
        begin
            tests_failed++;
            $display("test %0d %s: failed with %0d mismatches", test_num, name, n);
        end
        errors_before = errors;
    endtask

    // cycles since reset release, 0 before the first edge
    always @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            cyc <= 0;
        else
            cyc <= cyc + 1;
    end

    // ------------------------------
    // compare on the falling edge
    // ------------------------------

    always @(negedge clk)
    begin : compare
        key_t        rise;
        count_t      count_prev;
        led_t        exp_led;
        digit_t      exp_digit;
        logic [23:0] exp_rgb;
        logic        exp_hsync;
        logic        exp_vsync;
        logic        exp_display;
        int          idx;

        if (!arst_n)
        begin
            if (LED !== '1)
                flag_mismatch("LED", {w_led{1'b1}}, LED);
            if (hsync !== 1'b1)
                flag_mismatch("hsync", 1, hsync);
            if (vsync !== 1'b1)
                flag_mismatch("vsync", 1, vsync);
            if (digit !== digit_t'(1))
                flag_mismatch("digit", 1, digit);

            count        = '0;
            mode         = mode_bars;
            color_hold   = 0;
            segs_hold    = 0;
            rise_seen    = 1'b0;
            display_prev = 1'b1;
            for (int i = 0; i < 5; i++)
                pressed[i] = '0;
        end
        else
        begin
            tx = cyc % h_total;
            ty = (cyc / h_total) % v_total;

            // key pins take effect three edges after they change
            for (int i = 4; i > 0; i--)
                pressed[i] = pressed[i - 1];
            pressed[0] = ~KEY;
            rise = pressed[3] & ~pressed[4];

            count_prev = count;
            if (rise[1])
                count = '0;
            else if (cyc > slow_div && (cyc - 1) % slow_div == 0)
                count = count + 1'b1;

            if (rise[0])
                mode = tb_board.next_mode(mode);

            exp_led = ~count[w_led - 1:0];
            if (LED !== exp_led)
                flag_mismatch("LED", exp_led, LED);

            // raster flags at the tracked position
            exp_hsync = !(tx >= h_active + h_front && tx < h_active + h_front + h_sync);
            exp_vsync = !(ty >= v_active + v_front && ty < v_active + v_front + v_sync);
            exp_display = (tx < h_active) && (ty < v_active);
            if (hsync !== exp_hsync)
                flag_mismatch("hsync", exp_hsync, hsync);
            if (vsync !== exp_vsync)
                flag_mismatch("vsync", exp_vsync, vsync);
            if (display_on !== exp_display)
                flag_mismatch("display_on", exp_display, display_on);

            // high from reset, so the first rise opens line 1
            if (display_on && !display_prev && !rise_seen)
            begin
                rise_seen = 1'b1;
                if (tx != 0 || ty != 1)
                    flag_event($sformatf("display_on first rose at x %0d y %0d, not at line 1",
                                         tx, ty));
            end
            display_prev = display_on;

            // colours, paused around a mode key press
            if (pressed[0][0] && !pressed[1][0])
                color_hold = 4;
            else if (color_hold > 0)
                color_hold--;

            if (color_hold == 0)
            begin
                exp_rgb = tb_board.exp_color(tx, ty, mode);
                if (red !== exp_rgb[23:16])
                    flag_mismatch("red", exp_rgb[23:16], red);
                if (green !== exp_rgb[15:8])
                    flag_mismatch("green", exp_rgb[15:8], green);
                if (blue !== exp_rgb[7:0])
                    flag_mismatch("blue", exp_rgb[7:0], blue);
            end

            // one digit per scan_div cycles, starting at position 0
            exp_digit = digit_t'(1) << ((cyc / scan_div) % w_digit);
            if (digit !== exp_digit)
                flag_mismatch("digit", exp_digit, digit);

            // segments lag a count change by one cycle
            if (count != count_prev)
                segs_hold = 2;
            else if (segs_hold > 0)
                segs_hold--;

            if (segs_hold == 0 && cyc > 0 && $onehot(digit))
            begin
                idx = 0;
                for (int i = 0; i < w_digit; i++)
                    if (digit[i])
                        idx = i;
                if (abcdefgh !== tb_board.exp_segs(count[4 * idx +: 4]))
                    flag_mismatch("abcdefgh", tb_board.exp_segs(count[4 * idx +: 4]), abcdefgh);
            end
        end
    end

endmodule

// File: board_properties.sv
`timescale 1ns/10ps

module board_properties
(
    input logic          clk,
    input logic          arst_n,
    input logic          hsync,
    input logic          vsync,
    input logic          display_on,
    input video_pkg::x_t x,
    input video_pkg::y_t y
);

    import video_pkg::*;

    // read by the testbench top at the end of the run
    int failures = 0;

    // sync pulses only in the blanking area
    sync_outside_active: assert property (@(posedge clk) disable iff (!arst_n)
        display_on |-> (hsync && vsync))
    else
    begin
        $error("sync pulse low while display_on is high");
        failures++;
    end

    x_in_range: assert property (@(posedge clk) disable iff (!arst_n)
        x < x_t'(h_total))
    else
    begin
        $error("x out of range: %0d", x);
        failures++;
    end

    y_in_range: assert property (@(posedge clk) disable iff (!arst_n)
        y < y_t'(v_total))
    else
    begin
        $error("y out of range: %0d", y);
        failures++;
    end

endmodule

bind vga_timing board_properties props
(
    .clk        ( clk        ),
    .arst_n     ( arst_n     ),
    .hsync      ( hsync      ),
    .vsync      ( vsync      ),
    .display_on ( display_on ),
    .x          ( x          ),
    .y          ( y          )
);

// File: board_specific_top.sv
`timescale 1ns/10ps

module board_specific_top
#(
    parameter int slow_div = board_pkg::slow_div
)
(
    input  logic              clk,
    input  logic              arst_n,
    input  board_pkg::key_t   KEY,
    output board_pkg::led_t   LED,
    output board_pkg::segs_t  abcdefgh,
    output board_pkg::digit_t digit,
    output logic              hsync,
    output logic              vsync,
    output logic              display_on,
    output video_pkg::color_t red,
    output video_pkg::color_t green,
    output video_pkg::color_t blue
);

    import board_pkg::*;
    import video_pkg::*;

    key_t   lab_key;
    led_t   lab_led;
    count_t count;
    logic   slow_strobe;
    x_t     x;
    y_t     y;

    // ------------------------------
    // board polarity, keys and LEDs active low
    // ------------------------------

    assign lab_key = ~KEY;
    assign LED     = ~lab_led;

    // ------------------------------
    // timing sources
    // ------------------------------

    slow_clk_gen #(.slow_div (slow_div)) i_slow_clk_gen
    (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .slow_strobe ( slow_strobe )
    );

    vga_timing i_vga_timing
    (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .hsync       ( hsync       ),
        .vsync       ( vsync       ),
        .display_on  ( display_on  ),
        .x           ( x           ),
        .y           ( y           )
    );

    // ------------------------------
    // lab and display
    // ------------------------------

    lab_top i_lab_top
    (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .slow_strobe ( slow_strobe ),
        .key         ( lab_key     ),
        .x           ( x           ),
        .y           ( y           ),
        .display_on  ( display_on  ),
        .led         ( lab_led     ),
        .count       ( count       ),
        .red         ( red         ),
        .green       ( green       ),
        .blue        ( blue        )
    );

    seven_seg_scan i_seven_seg_scan
    (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .value       ( count       ),
        .abcdefgh    ( abcdefgh    ),
        .digit       ( digit       )
    );

endmodule

// File: lab_top.sv
`timescale 1ns/10ps

module lab_top
(
    input  logic               clk,
    input  logic               arst_n,
    input  logic               slow_strobe,
    input  board_pkg::key_t    key,
    input  video_pkg::x_t      x,
    input  video_pkg::y_t      y,
    input  logic               display_on,
    output board_pkg::led_t    led,
    output board_pkg::count_t  count,
    output video_pkg::color_t  red,
    output video_pkg::color_t  green,
    output video_pkg::color_t  blue
);

    import board_pkg::*;
    import video_pkg::*;

    key_t  key_s1;
    key_t  key_s2;
    key_t  key_q;
    key_t  key_rise;
    mode_t mode;
    mode_t mode_next;

    // ------------------------------
    // key synchroniser and edges
    // ------------------------------

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            key_s1 <= '0;
            key_s2 <= '0;
            key_q  <= '0;
        end
        else
        begin
            key_s1 <= key;
            key_s2 <= key_s1;
            key_q  <= key_s2;
        end
    end

    assign key_rise = key_s2 & ~key_q;

    // ------------------------------
    // pattern mode
    // ------------------------------

    always_comb
    begin
        case (mode)
            mode_bars:    mode_next = mode_checker;
            mode_checker: mode_next = mode_solid;
            default:      mode_next = mode_bars;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            mode <= mode_bars;
        else if (key_rise[0])
            mode <= mode_next;
    end

    // ------------------------------
    // strobe counter
    // ------------------------------

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            count <= '0;
        else if (key_rise[1])
            // clear wins over a strobe in the same cycle
            count <= '0;
        else if (slow_strobe)
            count <= count + 1'b1;
    end

    assign led = count[w_led - 1:0];

    // ------------------------------
    // pixel colour
    // ------------------------------

    always_comb
    begin
        red   = '0;
        green = '0;
        blue  = '0;

        if (display_on)
        begin
            case (mode)
                mode_bars:
                begin
                    // eight vertical bars of 64 pixels
                    red   = {$bits(color_t){x[6]}};
                    green = {$bits(color_t){x[7]}};
                    blue  = {$bits(color_t){x[8]}};
                end
                mode_checker:
                begin
                    red   = {$bits(color_t){x[5] ^ y[5]}};
                    green = {$bits(color_t){x[5] ^ y[5]}};
                    blue  = {$bits(color_t){x[5] ^ y[5]}};
                end
                default:
                begin
                    red   = '1;
                    green = '1;
                    blue  = '1;
                end
            endcase
        end
    end

endmodule

// File: seven_seg_scan.sv
`timescale 1ns/10ps

module seven_seg_scan
(
    input  logic              clk,
    input  logic              arst_n,
    input  board_pkg::count_t value,
    output board_pkg::segs_t  abcdefgh,
    output board_pkg::digit_t digit
);

    import board_pkg::*;

    localparam int w_pre = $clog2(scan_div);
    localparam int w_pos = $clog2(w_digit);

    logic [w_pre - 1:0] pre;
    logic [w_pos - 1:0] pos;
    logic [w_pos - 1:0] pos_next;
    logic               tick;
    logic [3:0]         nibble;

    // hex digit to segments, a is the top bit, dot off
    function automatic segs_t hex_to_segs(input logic [3:0] hex);
        case (hex)
            4'h0:    return 8'b1111_1100;
            4'h1:    return 8'b0110_0000;
            4'h2:    return 8'b1101_1010;
            4'h3:    return 8'b1111_0010;
            4'h4:    return 8'b0110_0110;
            4'h5:    return 8'b1011_0110;
            4'h6:    return 8'b1011_1110;
            4'h7:    return 8'b1110_0000;
            4'h8:    return 8'b1111_1110;
            4'h9:    return 8'b1111_0110;
            4'ha:    return 8'b1110_1110;
            4'hb:    return 8'b0011_1110;
            4'hc:    return 8'b1001_1100;
            4'hd:    return 8'b0111_1010;
            4'he:    return 8'b1001_1110;
            default: return 8'b1000_1110;
        endcase
    endfunction

    // ------------------------------
    // digit prescaler and position
    // ------------------------------

    assign tick     = (pre == w_pre'(scan_div - 1));
    assign pos_next = tick ? pos + 1'b1 : pos;

    // position 0 shows the least significant nibble
    assign nibble = value[4 * pos_next +: 4];

    // segments and digit select share one register stage
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pre      <= '0;
            pos      <= '0;
            digit    <= digit_t'(1);
            abcdefgh <= '0;
        end
        else
        begin
            pre      <= tick ? '0 : pre + 1'b1;
            pos      <= pos_next;
            digit    <= digit_t'(1) << pos_next;
            abcdefgh <= hex_to_segs(nibble);
        end
    end

endmodule

// File: vga_timing.sv
`timescale 1ns/10ps

module vga_timing
(
    input  logic          clk,
    input  logic          arst_n,
    output logic          hsync,
    output logic          vsync,
    output logic          display_on,
    output video_pkg::x_t x,
    output video_pkg::y_t y
);

    import video_pkg::*;

    x_t   x_next;
    y_t   y_next;
    logic end_of_line;
    logic end_of_frame;
    logic hsync_next;
    logic vsync_next;
    logic display_on_next;

    assign end_of_line  = (x == x_t'(h_total - 1));
    assign end_of_frame = (y == y_t'(v_total - 1));

    // ------------------------------
    // next counter values
    // ------------------------------

    always_comb
    begin
        if (end_of_line)
            x_next = '0;
        else
            x_next = x + 1'b1;

        if (!end_of_line)
            y_next = y;
        else if (end_of_frame)
            y_next = '0;
        else
            y_next = y + 1'b1;
    end

    // ------------------------------
    // flags from the next position
    // ------------------------------

    always_comb
    begin
        // syncs are active low
        hsync_next = !((x_next >= x_t'(h_active + h_front))
                    && (x_next <  x_t'(h_active + h_front + h_sync)));

        vsync_next = !((y_next >= y_t'(v_active + v_front))
                    && (y_next <  y_t'(v_active + v_front + v_sync)));

        display_on_next = (x_next < x_t'(h_active)) && (y_next < y_t'(v_active));
    end

    // flags and coordinates share one register stage
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            x          <= '0;
            y          <= '0;
            hsync      <= 1'b1;
            vsync      <= 1'b1;
            // position 0,0 is inside the active area
            display_on <= 1'b1;
        end
        else
        begin
            x          <= x_next;
            y          <= y_next;
            hsync      <= hsync_next;
            vsync      <= vsync_next;
            display_on <= display_on_next;
        end
    end

endmodule

// File: slow_clk_gen.sv
`timescale 1ns/10ps

module slow_clk_gen
#(
    parameter int slow_div = board_pkg::slow_div
)
(
    input  logic clk,
    input  logic arst_n,
    output logic slow_strobe
);

    // wide enough to hold slow_div - 1
    localparam int w_cnt = $clog2(slow_div + 1);

    logic [w_cnt - 1:0] cnt;
    logic               cnt_zero;

    assign cnt_zero = (cnt == '0);

    // down-counter, reloads after reaching zero
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            cnt         <= w_cnt'(slow_div - 1);
            slow_strobe <= 1'b0;
        end
        else
        begin
            slow_strobe <= cnt_zero;

            if (cnt_zero)
                cnt <= w_cnt'(slow_div - 1);
            else
                cnt <= cnt - 1'b1;
        end
    end

endmodule

// File: video_pkg.sv
package video_pkg;

    // ------------------------------
    // horizontal timing, in pixels
    // ------------------------------

    localparam int h_active = 640;
    localparam int h_front  = 16;
    localparam int h_sync   = 96;
    localparam int h_back   = 48;
    localparam int h_total  = h_active + h_front + h_sync + h_back;

    // ------------------------------
    // vertical timing, in lines
    // ------------------------------

    localparam int v_active = 480;
    localparam int v_front  = 10;
    localparam int v_sync   = 2;
    localparam int v_back   = 33;
    localparam int v_total  = v_active + v_front + v_sync + v_back;

    // ------------------------------
    // pixel types
    // ------------------------------

    typedef logic [9:0] x_t;
    typedef logic [9:0] y_t;

    // one colour channel
    typedef logic [7:0] color_t;

    // test pattern selection
    typedef enum logic [1:0]
    {
        mode_bars,
        mode_checker,
        mode_solid
    } mode_t;

endpackage

// File: board_pkg.sv
package board_pkg;

    // ------------------------------
    // board resources
    // ------------------------------

    localparam int w_key   = 2;
    localparam int w_led   = 6;
    localparam int w_digit = 4;

    // width of the strobe counter shown on LEDs and display
    localparam int w_count = 16;

    // ------------------------------
    // clock division
    // ------------------------------

    // one slow strobe per second at 27 MHz
    localparam int slow_div = 27_000_000;

    // clk cycles spent on each display digit
    localparam int scan_div = 256;

    // ------------------------------
    // vector types
    // ------------------------------

    typedef logic [w_key   - 1:0] key_t;
    typedef logic [w_led   - 1:0] led_t;
    typedef logic [w_digit - 1:0] digit_t;
    typedef logic [w_count - 1:0] count_t;

    // segment a in bit 7, dot (h) in bit 0
    typedef logic [7:0]           segs_t;

endpackage
